/* rtl/csu_pkg.sv */
// CSR unit shared definitions
package csu_pkg;

  localparam int XLEN  = 32;
  localparam int TAG_W = 4;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [4:0]      reg_idx_t;

  // ----------------------------------------------------------------------
  // instruction fields
  // ----------------------------------------------------------------------
  localparam logic [6:0]  OPCODE_SYSTEM  = 7'b1110011;
  localparam logic [2:0]  F3_PRIV        = 3'b000;
  localparam logic [11:0] F12_ECALL      = 12'h000;
  localparam logic [11:0] F12_EBREAK     = 12'h001;
  localparam logic [11:0] F12_SRET       = 12'h102;
  localparam logic [11:0] F12_MRET       = 12'h302;

  // ----------------------------------------------------------------------
  // CSR addresses
  // ----------------------------------------------------------------------
  localparam csr_addr_t CSR_FFLAGS   = 12'h001;
  localparam csr_addr_t CSR_FRM      = 12'h002;
  localparam csr_addr_t CSR_FCSR     = 12'h003;
  localparam csr_addr_t CSR_SSCRATCH = 12'h140;
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MISA     = 12'h301;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MINSTRET = 12'hB02;
  localparam csr_addr_t CSR_MHARTID  = 12'hF14;

  // mstatus fields
  localparam int MSTATUS_FS_LSB  = 13;
  localparam int MSTATUS_TSR_BIT = 22;

  // RISC-V encoding, so address bits 9:8 compare directly
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_RW,
    OP_RS,
    OP_RC
  } csu_op_t;

  typedef enum logic [3:0] {
    EXC_SILENT_FLUSH,
    EXC_ILLEGAL_INST,
    EXC_MRET,
    EXC_SRET,
    EXC_ECALL_U,
    EXC_ECALL_S,
    EXC_ECALL_M,
    EXC_BREAKPOINT
  } except_t;

  // ----------------------------------------------------------------------
  // pipeline structs
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [31:0]      inst;
  } issue_t;

  typedef struct packed {
    csu_op_t op;
    logic    is_mret;
    logic    is_sret;
    logic    is_ecall;
    logic    is_ebreak;
    logic    csr_access;
    logic    use_rs1;
    logic    rd_valid;
  } pipe_ctrl_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t index;
  } reg_rd_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t index;
    xlen_t    data;
  } reg_wr_t;

  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
  } csr_rd_req_t;

  typedef struct packed {
    xlen_t data;
    logic  error;
  } csr_rd_resp_t;

  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
    xlen_t     data;
  } csr_wr_req_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic             except_valid;
    except_t          except_type;
    xlen_t            tval;
  } done_t;

endpackage

/* rtl/csu_decoder.sv */
// SYSTEM instruction decoder
`timescale 1ns/10ps

module csu_decoder
  import csu_pkg::*;
(
  input  logic [31:0] i_inst,
  output pipe_ctrl_t  o_ctrl
);

  logic [6:0]  w_opcode;
  logic [2:0]  w_funct3;
  logic [11:0] w_funct12;
  reg_idx_t    w_rs1;
  reg_idx_t    w_rd;
  logic        w_is_system;
  logic        w_is_priv;

  assign w_opcode  = i_inst[6:0];
  assign w_funct3  = i_inst[14:12];
  assign w_funct12 = i_inst[31:20];
  assign w_rs1     = i_inst[19:15];
  assign w_rd      = i_inst[11:7];

  assign w_is_system = (w_opcode == OPCODE_SYSTEM);
  // privileged forms need rs1 and rd both zero
  assign w_is_priv   = w_is_system && (w_funct3 == F3_PRIV) &&
                       (w_rs1 == '0) && (w_rd == '0);

  always_comb begin
    o_ctrl = '0;
    o_ctrl.op = OP_NONE;

    if (w_is_system && (w_funct3[1:0] != 2'b00)) begin
      o_ctrl.csr_access = 1'b1;
      case (w_funct3[1:0])
        2'b01:   o_ctrl.op = OP_RW;
        2'b10:   o_ctrl.op = OP_RS;
        default: o_ctrl.op = OP_RC;
      endcase
      // funct3[2] selects the uimm form
      o_ctrl.use_rs1  = !w_funct3[2];
      o_ctrl.rd_valid = (w_rd != '0);
    end

    if (w_is_priv) begin
      o_ctrl.is_ecall  = (w_funct12 == F12_ECALL);
      o_ctrl.is_ebreak = (w_funct12 == F12_EBREAK);
      o_ctrl.is_sret   = (w_funct12 == F12_SRET);
      o_ctrl.is_mret   = (w_funct12 == F12_MRET);
    end
  end

endmodule

/* rtl/csu_pipe.sv */
// CSR execution pipe
`timescale 1ns/10ps

module csu_pipe
  import csu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,

  input  issue_t       i_issue,
  input  pipe_ctrl_t   i_ctrl,

  output reg_rd_t      o_reg_rd,
  input  xlen_t        i_reg_rd_data,

  output csr_rd_req_t  o_csr_rd,
  input  csr_rd_resp_t i_csr_rd,

  output csr_wr_req_t  o_csr_wr,
  input  logic         i_csr_wr_error,

  input  priv_t        i_priv,
  input  xlen_t        i_mstatus,

  output reg_wr_t      o_rd_wr,
  output done_t        o_done
);

  issue_t     r_ex1_issue;
  pipe_ctrl_t r_ex1_ctrl;
  issue_t     r_ex2_issue;
  pipe_ctrl_t r_ex2_ctrl;
  issue_t     r_ex3_issue;
  pipe_ctrl_t r_ex3_ctrl;
  logic       r_ex3_csr_illegal;
  xlen_t      r_ex3_result;
  xlen_t      r_ex3_old;

  xlen_t      w_ex2_operand;
  xlen_t      w_ex2_result;
  csr_addr_t  w_ex2_addr;
  logic       w_ex2_fs_illegal;
  logic       w_ex2_illegal;

  logic       w_ex3_no_write;
  logic       w_ex3_wants_write;
  logic       w_ex3_illegal;

  // ----------------------------------------------------------------------
  // ex0 -> ex1, ex1 -> ex2 staging
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= i_ctrl;
      r_ex2_issue <= r_ex1_issue;
      r_ex2_ctrl  <= r_ex1_ctrl;
    end
  end

  // ex1 register read, data returns in ex2
  assign o_reg_rd.valid = r_ex1_issue.valid & r_ex1_ctrl.use_rs1;
  assign o_reg_rd.index = r_ex1_issue.inst[19:15];

  // ----------------------------------------------------------------------
  // ex2 CSR read and new value
  // ----------------------------------------------------------------------
  assign w_ex2_addr    = r_ex2_issue.inst[31:20];
  assign w_ex2_operand = r_ex2_ctrl.use_rs1 ? i_reg_rd_data :
                         {{(XLEN-5){1'b0}}, r_ex2_issue.inst[19:15]};

  assign o_csr_rd.valid = r_ex2_issue.valid & r_ex2_ctrl.csr_access;
  assign o_csr_rd.addr  = w_ex2_addr;

  // float CSRs are off while FS is 0
  assign w_ex2_fs_illegal = ((w_ex2_addr == CSR_FFLAGS) || (w_ex2_addr == CSR_FRM) ||
                             (w_ex2_addr == CSR_FCSR)) &&
                            (i_mstatus[MSTATUS_FS_LSB +: 2] == 2'b00);
  assign w_ex2_illegal    = o_csr_rd.valid & (i_csr_rd.error | w_ex2_fs_illegal);

  always_comb begin
    case (r_ex2_ctrl.op)
      OP_RW:   w_ex2_result = w_ex2_operand;
      OP_RS:   w_ex2_result = i_csr_rd.data | w_ex2_operand;
      OP_RC:   w_ex2_result = i_csr_rd.data & ~w_ex2_operand;
      default: w_ex2_result = '0;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_issue       <= '0;
      r_ex3_ctrl        <= '0;
      r_ex3_csr_illegal <= 1'b0;
    end else begin
      r_ex3_issue       <= r_ex2_issue;
      r_ex3_ctrl        <= r_ex2_ctrl;
      r_ex3_csr_illegal <= w_ex2_illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_result <= w_ex2_result;
    r_ex3_old    <= i_csr_rd.data;
  end

  // ----------------------------------------------------------------------
  // ex3 write back and completion
  // ----------------------------------------------------------------------
  // set/clear with rs1 = x0 only reads
  assign w_ex3_no_write    = ((r_ex3_ctrl.op == OP_RS) || (r_ex3_ctrl.op == OP_RC)) &&
                             r_ex3_ctrl.use_rs1 && (r_ex3_issue.inst[19:15] == '0);
  assign w_ex3_wants_write = r_ex3_issue.valid & r_ex3_ctrl.csr_access & !w_ex3_no_write;

  assign w_ex3_illegal = r_ex3_csr_illegal |
                         (r_ex3_ctrl.is_sret & i_mstatus[MSTATUS_TSR_BIT]) |
                         (w_ex3_wants_write & i_csr_wr_error);

  assign o_csr_wr.valid = w_ex3_wants_write & !w_ex3_illegal;
  assign o_csr_wr.addr  = r_ex3_issue.inst[31:20];
  assign o_csr_wr.data  = r_ex3_result;

  // rd gets the value before the update
  assign o_rd_wr.valid = r_ex3_issue.valid & r_ex3_ctrl.rd_valid & !w_ex3_illegal;
  assign o_rd_wr.index = r_ex3_issue.inst[11:7];
  assign o_rd_wr.data  = r_ex3_old;

  assign o_done.valid        = r_ex3_issue.valid;
  assign o_done.tag          = r_ex3_issue.tag;
  assign o_done.except_valid = r_ex3_ctrl.csr_access | r_ex3_ctrl.is_mret |
                               r_ex3_ctrl.is_sret | r_ex3_ctrl.is_ecall |
                               r_ex3_ctrl.is_ebreak | w_ex3_illegal;
  assign o_done.tval         = w_ex3_illegal ? r_ex3_issue.inst : '0;

  always_comb begin
    if (w_ex3_illegal) begin
      o_done.except_type = EXC_ILLEGAL_INST;
    end else if (r_ex3_ctrl.is_mret) begin
      o_done.except_type = EXC_MRET;
    end else if (r_ex3_ctrl.is_sret) begin
      o_done.except_type = EXC_SRET;
    end else if (r_ex3_ctrl.is_ecall) begin
      case (i_priv)
        PRIV_U:  o_done.except_type = EXC_ECALL_U;
        PRIV_S:  o_done.except_type = EXC_ECALL_S;
        default: o_done.except_type = EXC_ECALL_M;
      endcase
    end else if (r_ex3_ctrl.is_ebreak) begin
      o_done.except_type = EXC_BREAKPOINT;
    end else begin
      o_done.except_type = EXC_SILENT_FLUSH;
    end
  end

  // an illegal report must never reach the CSR file as a write
  a_no_illegal_write : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_csr_wr.valid && o_done.valid && (o_done.except_type == EXC_ILLEGAL_INST)));

endmodule

/* rtl/csr_file.sv */
// Machine and supervisor CSR file
`timescale 1ns/10ps

module csr_file
  import csu_pkg::*;
#(
  parameter int unsigned HART_ID = 0
)(
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  priv_t        i_priv,

  input  csr_rd_req_t  i_rd,
  output csr_rd_resp_t o_rd,

  input  csr_wr_req_t  i_wr,
  output logic         o_wr_error,

  input  done_t        i_done,

  output xlen_t        o_mstatus
);

  // RV32 with I, S and U
  localparam xlen_t MISA_VALUE    = 32'h4014_0100;
  // SIE MIE SPIE MPIE SPP MPP FS TSR
  localparam xlen_t MSTATUS_WMASK = 32'h0040_79AA;

  xlen_t      r_mstatus;
  xlen_t      r_mscratch;
  xlen_t      r_mepc;
  xlen_t      r_sscratch;
  logic [4:0] r_fflags;
  logic [2:0] r_frm;
  xlen_t      r_minstret;

  xlen_t      w_rd_data;
  logic       w_rd_known;
  logic       w_rd_priv_low;
  logic       w_wr_en;
  logic       w_retire;

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------
  always_comb begin
    w_rd_data  = '0;
    w_rd_known = 1'b1;
    case (i_rd.addr)
      CSR_MSTATUS:  w_rd_data = r_mstatus;
      CSR_MISA:     w_rd_data = MISA_VALUE;
      CSR_MSCRATCH: w_rd_data = r_mscratch;
      CSR_MEPC:     w_rd_data = r_mepc;
      CSR_SSCRATCH: w_rd_data = r_sscratch;
      CSR_FFLAGS:   w_rd_data = {{(XLEN-5){1'b0}}, r_fflags};
      CSR_FRM:      w_rd_data = {{(XLEN-3){1'b0}}, r_frm};
      CSR_FCSR:     w_rd_data = {{(XLEN-8){1'b0}}, r_frm, r_fflags};
      CSR_MINSTRET: w_rd_data = r_minstret;
      CSR_MHARTID:  w_rd_data = XLEN'(HART_ID);
      default:      w_rd_known = 1'b0;
    endcase
  end

  // address bits 9:8 give the lowest privilege allowed
  assign w_rd_priv_low = (i_rd.addr[9:8] > 2'(i_priv));

  assign o_rd.data  = w_rd_data;
  assign o_rd.error = i_rd.valid & (!w_rd_known | w_rd_priv_low);

  // ----------------------------------------------------------------------
  // write side
  // ----------------------------------------------------------------------
  // depends on the address only, the pipe folds it into its write enable
  assign o_wr_error = (i_wr.addr[11:10] == 2'b11);
  assign w_wr_en    = i_wr.valid & !o_wr_error;
  assign w_retire   = i_done.valid & !i_done.except_valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mstatus  <= '0;
      r_mscratch <= '0;
      r_mepc     <= '0;
      r_sscratch <= '0;
      r_fflags   <= '0;
      r_frm      <= '0;
    end else if (w_wr_en) begin
      case (i_wr.addr)
        CSR_MSTATUS:  r_mstatus  <= i_wr.data & MSTATUS_WMASK;
        CSR_MSCRATCH: r_mscratch <= i_wr.data;
        CSR_MEPC:     r_mepc     <= {i_wr.data[XLEN-1:1], 1'b0};
        CSR_SSCRATCH: r_sscratch <= i_wr.data;
        CSR_FFLAGS:   r_fflags   <= i_wr.data[4:0];
        CSR_FRM:      r_frm      <= i_wr.data[2:0];
        CSR_FCSR: begin
          r_fflags <= i_wr.data[4:0];
          r_frm    <= i_wr.data[7:5];
        end
        default: ;
      endcase
    end
  end

  // explicit write wins over the retire count
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_minstret <= '0;
    end else if (w_wr_en && (i_wr.addr == CSR_MINSTRET)) begin
      r_minstret <= i_wr.data;
    end else if (w_retire) begin
      r_minstret <= r_minstret + 1'b1;
    end
  end

  assign o_mstatus = r_mstatus;

  a_no_write_on_error : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_wr.valid && o_wr_error) |=>
      ($stable(r_mstatus) && $stable(r_mscratch) && $stable(r_mepc) &&
       $stable(r_sscratch) && $stable(r_fflags) && $stable(r_frm)));

endmodule

/* rtl/int_regfile.sv */
// Integer register file
`timescale 1ns/10ps

module int_regfile
  import csu_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,

  input  reg_rd_t i_rd,
  output xlen_t   o_rd_data,

  input  reg_wr_t i_wr_a,
  input  reg_wr_t i_wr_b
);

  xlen_t r_regs [32];
  xlen_t r_rd_data;

  // port b is assigned last so it wins a same-index conflict
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_regs <= '{default: '0};
    end else begin
      if (i_wr_a.valid && (i_wr_a.index != '0)) begin
        r_regs[i_wr_a.index] <= i_wr_a.data;
      end
      if (i_wr_b.valid && (i_wr_b.index != '0)) begin
        r_regs[i_wr_b.index] <= i_wr_b.data;
      end
    end
  end

  // registered read, no bypass of same-cycle writes
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_data <= '0;
    end else if (i_rd.valid) begin
      r_rd_data <= r_regs[i_rd.index];
    end
  end

  assign o_rd_data = r_rd_data;

  a_x0_zero : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_regs[0] == '0);

endmodule

/* rtl/csu_top.sv */
// CSR execution unit top level
`timescale 1ns/10ps

module csu_top
  import csu_pkg::*;
#(
  parameter int unsigned HART_ID = 0
)(
  input  logic    i_clk,
  input  logic    i_reset_n,

  input  issue_t  i_issue,
  input  priv_t   i_priv,
  input  reg_wr_t i_ext_wr,

  output done_t   o_done,
  output reg_wr_t o_rd_wr
);

  pipe_ctrl_t   w_ctrl;
  reg_rd_t      w_reg_rd;
  xlen_t        w_reg_rd_data;
  csr_rd_req_t  w_csr_rd_req;
  csr_rd_resp_t w_csr_rd_resp;
  csr_wr_req_t  w_csr_wr;
  logic         w_csr_wr_error;
  xlen_t        w_mstatus;

  // ex0 decode
  csu_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ctrl)
  );

  csu_pipe u_pipe (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue        (i_issue),
    .i_ctrl         (w_ctrl),
    .o_reg_rd       (w_reg_rd),
    .i_reg_rd_data  (w_reg_rd_data),
    .o_csr_rd       (w_csr_rd_req),
    .i_csr_rd       (w_csr_rd_resp),
    .o_csr_wr       (w_csr_wr),
    .i_csr_wr_error (w_csr_wr_error),
    .i_priv         (i_priv),
    .i_mstatus      (w_mstatus),
    .o_rd_wr        (o_rd_wr),
    .o_done         (o_done)
  );

  csr_file #(
    .HART_ID (HART_ID)
  ) u_csr_file (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_priv     (i_priv),
    .i_rd       (w_csr_rd_req),
    .o_rd       (w_csr_rd_resp),
    .i_wr       (w_csr_wr),
    .o_wr_error (w_csr_wr_error),
    .i_done     (o_done),
    .o_mstatus  (w_mstatus)
  );

  // external units on port b
  int_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd      (w_reg_rd),
    .o_rd_data (w_reg_rd_data),
    .i_wr_a    (o_rd_wr),
    .i_wr_b    (i_ext_wr)
  );

endmodule

/* tests/csu_tb.sv */
// CSR unit testbench
`timescale 1ns/10ps

module csu_tb
  import csu_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int HART_ID         = 5;
  localparam int WATCHDOG_MARGIN = 100;

  localparam logic [2:0]  F3_RW  = 3'b001;
  localparam logic [2:0]  F3_RS  = 3'b010;
  localparam logic [2:0]  F3_RC  = 3'b011;
  localparam logic [2:0]  F3_RWI = 3'b101;
  localparam logic [2:0]  F3_RSI = 3'b110;
  localparam logic [2:0]  F3_RCI = 3'b111;
  localparam logic [31:0] NOP    = 32'h0000_0013;
  localparam csr_addr_t   CSR_UNKNOWN = 12'h7C0;

  typedef struct {
    done_t   done;
    reg_wr_t rd;
  } exp_t;

  logic    i_clk;
  logic    i_reset_n;
  issue_t  i_issue;
  priv_t   i_priv;
  reg_wr_t i_ext_wr;
  done_t   o_done;
  reg_wr_t o_rd_wr;

  // scoreboard
  exp_t             exp_q[$];
  exp_t             head;
  done_t            exp_done;
  reg_wr_t          exp_rd;
  int               n_errors = 0;
  int               n_done   = 0;
  int               n_issued = 0;
  logic [TAG_W-1:0] next_tag;

  // reference model state
  xlen_t      m_regs [32];
  xlen_t      m_mscratch;
  xlen_t      m_sscratch;
  xlen_t      m_minstret;
  logic [1:0] m_fs;
  logic       m_tsr;
  priv_t      cur_priv;

  csu_top #(
    .HART_ID (HART_ID)
  ) uut (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .i_priv    (i_priv),
    .i_ext_wr  (i_ext_wr),
    .o_done    (o_done),
    .o_rd_wr   (o_rd_wr)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD/2) i_clk = ~i_clk;
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic logic csr_known(input csr_addr_t addr);
    case (addr)
      CSR_FFLAGS, CSR_FRM, CSR_FCSR, CSR_SSCRATCH, CSR_MSTATUS, CSR_MISA,
      CSR_MSCRATCH, CSR_MEPC, CSR_MINSTRET, CSR_MHARTID: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic xlen_t model_read(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:  return (xlen_t'(m_tsr) << MSTATUS_TSR_BIT) |
                           (xlen_t'(m_fs) << MSTATUS_FS_LSB);
      CSR_MSCRATCH: return m_mscratch;
      CSR_SSCRATCH: return m_sscratch;
      CSR_MINSTRET: return m_minstret;
      CSR_MHARTID:  return xlen_t'(HART_ID);
      default:      return '0;
    endcase
  endfunction

  task automatic model_write(input csr_addr_t addr, input xlen_t data);
    case (addr)
      CSR_MSTATUS: begin
        m_fs  = data[MSTATUS_FS_LSB +: 2];
        m_tsr = data[MSTATUS_TSR_BIT];
      end
      CSR_MSCRATCH: m_mscratch = data;
      CSR_SSCRATCH: m_sscratch = data;
      default: ;
    endcase
  endtask

  // expected completion, updates the model as the instruction retires
  task automatic predict(input logic [31:0] inst, output exp_t e);
    logic [2:0] f3;
    reg_idx_t   rs1;
    reg_idx_t   rd;
    csr_addr_t  addr;
    xlen_t      operand;
    xlen_t      old_val;
    xlen_t      new_val;
    logic       writes;
    logic       is_fp;
    logic       illegal;
    f3   = inst[14:12];
    rs1  = inst[19:15];
    rd   = inst[11:7];
    addr = inst[31:20];
    e.done             = '0;
    e.rd               = '0;
    e.done.valid       = 1'b1;
    e.done.tag         = next_tag;
    e.done.except_type = EXC_SILENT_FLUSH;
    if ((inst[6:0] == OPCODE_SYSTEM) && (f3[1:0] != 2'b00)) begin
      operand = f3[2] ? xlen_t'(rs1) : m_regs[rs1];
      // set or clear from x0 only reads
      writes  = !((f3[1:0] != 2'b01) && !f3[2] && (rs1 == 5'd0));
      is_fp   = (addr == CSR_FFLAGS) || (addr == CSR_FRM) || (addr == CSR_FCSR);
      illegal = !csr_known(addr) || (addr[9:8] > 2'(cur_priv)) ||
                (is_fp && (m_fs == 2'b00)) || (writes && (addr[11:10] == 2'b11));
      old_val = model_read(addr);
      case (f3[1:0])
        2'b01:   new_val = operand;
        2'b10:   new_val = old_val | operand;
        default: new_val = old_val & ~operand;
      endcase
      e.done.except_valid = 1'b1;
      if (illegal) begin
        e.done.except_type = EXC_ILLEGAL_INST;
        e.done.tval        = inst;
      end else begin
        if (writes) begin
          model_write(addr, new_val);
        end
        if (rd != 5'd0) begin
          e.rd       = '{valid: 1'b1, index: rd, data: old_val};
          m_regs[rd] = old_val;
        end
      end
    end else if ((inst[6:0] == OPCODE_SYSTEM) && (inst[19:7] == '0)) begin
      e.done.except_valid = 1'b1;
      case (addr)
        F12_MRET:   e.done.except_type = EXC_MRET;
        F12_EBREAK: e.done.except_type = EXC_BREAKPOINT;
        F12_SRET: begin
          if (m_tsr) begin
            e.done.except_type = EXC_ILLEGAL_INST;
            e.done.tval        = inst;
          end else begin
            e.done.except_type = EXC_SRET;
          end
        end
        F12_ECALL: begin
          case (cur_priv)
            PRIV_U:  e.done.except_type = EXC_ECALL_U;
            PRIV_S:  e.done.except_type = EXC_ECALL_S;
            default: e.done.except_type = EXC_ECALL_M;
          endcase
        end
        default: begin
          e.done.except_valid = 1'b0;
          m_minstret          = m_minstret + 1;
        end
      endcase
    end else begin
      // anything else retires plainly
      m_minstret = m_minstret + 1;
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] csr_inst(input logic [2:0] f3, input csr_addr_t addr,
                                           input reg_idx_t src, input reg_idx_t rd);
    return {addr, src, f3, rd, OPCODE_SYSTEM};
  endfunction

  function automatic logic [31:0] sys_inst(input logic [11:0] f12);
    return {f12, 13'd0, OPCODE_SYSTEM};
  endfunction

  task automatic send(input logic [31:0] inst);
    exp_t e;
    predict(inst, e);
    exp_q.push_back(e);
    @(posedge i_clk);
    i_issue <= '{valid: 1'b1, tag: next_tag, inst: inst};
    next_tag = next_tag + 1'b1;
    n_issued++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      i_issue <= '0;
    end
  endtask

  // keeps the 4 cycle spacing for dependent instructions
  task automatic run(input logic [31:0] inst);
    send(inst);
    idle(3);
  endtask

  task automatic load_reg(input reg_idx_t idx, input xlen_t data);
    @(posedge i_clk);
    i_ext_wr <= '{valid: 1'b1, index: idx, data: data};
    @(posedge i_clk);
    i_ext_wr <= '0;
    m_regs[idx] = data;
  endtask

  task automatic set_priv(input priv_t p);
    @(posedge i_clk);
    i_priv <= p;
    cur_priv = p;
  endtask

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // head of the scoreboard, stable before the next rising edge
  always @(negedge i_clk) begin
    if (i_reset_n && o_done.valid) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        exp_done = '0;
        $display("completion with tag %0h at %0t matches no issued instruction",
                 o_done.tag, $time);
      end else begin
        head     = exp_q.pop_front();
        exp_done = head.done;
        exp_rd   = head.rd;
        n_done++;
      end
    end
  end

  a_latency : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue.valid |-> ##3 o_done.valid)
    else begin
      n_errors++;
      $display("CHECK FAILED %0t: no completion 3 cycles after issue", $time);
    end

  a_origin : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done.valid |-> $past(i_issue.valid, 3))
    else begin
      n_errors++;
      $display("CHECK FAILED %0t: completion without an issue 3 cycles earlier", $time);
    end

  a_done_value : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done.valid |-> (o_done == exp_done))
    else begin
      n_errors++;
      $display("CHECK FAILED %0t: done tag %0h exc %0b/%0d tval %h, exp %0h %0b/%0d %h",
               $time, $sampled(o_done.tag), $sampled(o_done.except_valid),
               $sampled(o_done.except_type), $sampled(o_done.tval),
               exp_done.tag, exp_done.except_valid, exp_done.except_type, exp_done.tval);
    end

  a_rd_value : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done.valid |-> ((o_rd_wr.valid == exp_rd.valid) &&
                      (!exp_rd.valid || ((o_rd_wr.index == exp_rd.index) &&
                                         (o_rd_wr.data == exp_rd.data)))))
    else begin
      n_errors++;
      $display("CHECK FAILED %0t: rd write %0b x%0d = %h, expected %0b x%0d = %h",
               $time, $sampled(o_rd_wr.valid), $sampled(o_rd_wr.index),
               $sampled(o_rd_wr.data), exp_rd.valid, exp_rd.index, exp_rd.data);
    end

  a_rd_with_done : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_rd_wr.valid |-> o_done.valid)
    else begin
      n_errors++;
      $display("CHECK FAILED %0t: rd write without a completion", $time);
    end

  a_quiet_in_reset : assert property (@(posedge i_clk)
    !i_reset_n |-> (!o_done.valid && !o_rd_wr.valid))
    else begin
      n_errors++;
      $display("CHECK FAILED %0t: valid output during reset", $time);
    end

  // watchdog, limit grows with the issued instruction count
  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= n_issued * 10 + WATCHDOG_MARGIN) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout: the test did not finish within %0d cycles", cycles);
    $display("errors: %0d, completions checked: %0d", n_errors + 1, n_done);
    $display("TB FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    i_reset_n  = 1'b0;
    i_issue    = '0;
    i_priv     = PRIV_M;
    i_ext_wr   = '0;
    cur_priv   = PRIV_M;
    next_tag   = '0;
    exp_done   = '0;
    exp_rd     = '0;
    m_regs     = '{default: '0};
    m_mscratch = '0;
    m_sscratch = '0;
    m_minstret = '0;
    m_fs       = 2'b00;
    m_tsr      = 1'b0;
    void'($urandom(42));
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    idle(2);

    for (int i = 1; i <= 4; i++) begin
      load_reg(reg_idx_t'(i), $urandom());
    end
    load_reg(5'd21, xlen_t'(1) << MSTATUS_TSR_BIT);

    // read-modify-write on the scratch registers
    run(csr_inst(F3_RW,  CSR_MSCRATCH, 5'd1,  5'd5));
    run(csr_inst(F3_RW,  CSR_MSCRATCH, 5'd2,  5'd6));
    run(csr_inst(F3_RWI, CSR_SSCRATCH, 5'd21, 5'd7));
    run(csr_inst(F3_RS,  CSR_MSCRATCH, 5'd3,  5'd8));
    run(csr_inst(F3_RC,  CSR_MSCRATCH, 5'd4,  5'd9));
    run(csr_inst(F3_RS,  CSR_MSCRATCH, 5'd0,  5'd10));
    run(csr_inst(F3_RC,  CSR_SSCRATCH, 5'd0,  5'd11));
    run(csr_inst(F3_RSI, CSR_SSCRATCH, 5'd10, 5'd12));
    run(csr_inst(F3_RCI, CSR_SSCRATCH, 5'd1,  5'd13));
    run(csr_inst(F3_RW,  CSR_MSCRATCH, 5'd5,  5'd14));
    run(csr_inst(F3_RS,  CSR_MSCRATCH, 5'd0,  5'd15));

    // illegal accesses from M
    run(csr_inst(F3_RW,  CSR_UNKNOWN, 5'd1, 5'd16));
    run(csr_inst(F3_RW,  CSR_MHARTID, 5'd1, 5'd16));
    run(csr_inst(F3_RSI, CSR_MHARTID, 5'd1, 5'd16));
    run(csr_inst(F3_RS,  CSR_FFLAGS,  5'd0, 5'd16));

    // privilege levels
    set_priv(PRIV_U);
    run(csr_inst(F3_RS, CSR_MSCRATCH, 5'd0, 5'd17));
    run(csr_inst(F3_RW, CSR_SSCRATCH, 5'd2, 5'd17));
    run(sys_inst(F12_ECALL));
    set_priv(PRIV_S);
    run(csr_inst(F3_RS, CSR_SSCRATCH, 5'd0, 5'd17));
    run(sys_inst(F12_ECALL));
    set_priv(PRIV_M);
    run(sys_inst(F12_ECALL));
    run(sys_inst(F12_EBREAK));
    run(sys_inst(F12_MRET));
    run(sys_inst(F12_SRET));

    // TSR set makes SRET illegal
    run(csr_inst(F3_RS, CSR_MSTATUS, 5'd21, 5'd0));
    run(sys_inst(F12_SRET));
    run(csr_inst(F3_RC, CSR_MSTATUS, 5'd21, 5'd18));
    run(sys_inst(F12_SRET));

    // state after the illegal attempts
    run(csr_inst(F3_RS, CSR_MSCRATCH, 5'd0, 5'd19));
    run(csr_inst(F3_RS, CSR_SSCRATCH, 5'd0, 5'd20));
    run(csr_inst(F3_RS, CSR_MHARTID,  5'd0, 5'd22));

    // retire counter across three plain instructions
    run(csr_inst(F3_RS, CSR_MINSTRET, 5'd0, 5'd23));
    run(NOP);
    run(NOP);
    run(NOP);
    run(csr_inst(F3_RS, CSR_MINSTRET, 5'd0, 5'd24));

    // independent issues on consecutive cycles
    send(NOP);
    send(csr_inst(F3_RS,  CSR_MHARTID,  5'd0, 5'd27));
    send(NOP);
    send(csr_inst(F3_RS,  CSR_MSCRATCH, 5'd0, 5'd28));
    send(csr_inst(F3_RWI, CSR_SSCRATCH, 5'd9, 5'd29));
    idle(6);

    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d issued instructions never completed", exp_q.size());
    end
    $display("errors: %0d, completions checked: %0d", n_errors, n_done);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/csu_pkg.sv
rtl/csu_decoder.sv
rtl/csu_pipe.sv
rtl/csr_file.sv
rtl/int_regfile.sv
rtl/csu_top.sv
tests/csu_tb.sv

/* Bender.yml */
package:
  name: csu

sources:
  - rtl/csu_pkg.sv
  - rtl/csu_decoder.sv
  - rtl/csu_pipe.sv
  - rtl/csr_file.sv
  - rtl/int_regfile.sv
  - rtl/csu_top.sv
  - target: test
    files:
      - tests/csu_tb.sv
